// File: flist.f
+incdir+hw
hw/addr_offset_pkg.sv
hw/delay_line.sv
hw/po_ram.sv
hw/thread_sequencer.sv
hw/po_memory.sv
hw/addr_offset_top.sv
test/addr_offset_sva.sv
test/addr_offset_checker.sv
test/addr_offset_tb.sv

// File: hw/addr_offset_config.svh
// Sizes and counts for the address-offset stage.
// Included by the package and by every RTL file that sizes logic from them.

`ifndef ADDR_OFFSET_CONFIG_SVH
`define ADDR_OFFSET_CONFIG_SVH

// Address width, offsets span the whole memory
`define AO_ADDR_WIDTH       10

// Increment field, sign bit included
`define AO_INCR_WIDTH       4

// PO/PI entries per thread and the index width
`define AO_PO_ADDR_WIDTH    2
`define AO_PO_ENTRY_COUNT   4

// Barrel threads, at least 3 so that write-back lands before the next read
`define AO_THREAD_COUNT     4
`define AO_THREAD_WIDTH     2

// First address of the indirect window, aligned to the entry count
`define AO_INDIRECT_BASE    10'h3F0

`endif

// File: hw/addr_offset_pkg.sv
// Types shared by the address-offset RTL and its testbench.
// Widths come from the config header.

`include "addr_offset_config.svh"

package addr_offset_pkg;

    // Memory address
    typedef logic [`AO_ADDR_WIDTH-1:0]    addr_t;

    // Thread number
    typedef logic [`AO_THREAD_WIDTH-1:0]  thread_t;

    // Entry index within one thread's bank
    typedef logic [`AO_PO_ADDR_WIDTH-1:0] po_index_t;

    // Increment magnitude, the sign is held apart
    typedef logic [`AO_INCR_WIDTH-2:0]    pi_mag_t;

    // One PO/PI entry
    // Increment added when pi_sign is 0, subtracted when 1
    typedef struct packed {
        addr_t   offset;
        logic    pi_sign;
        pi_mag_t pi_mag;
    } po_entry_t;

    // External write request into the write thread's bank
    typedef struct packed {
        logic      wren;
        po_index_t index;
        po_entry_t entry;
    } po_write_t;

endpackage

// File: hw/addr_offset_top.sv
// Address-offset stage of the barrel processor.
// Adds the thread's programmed offset to accesses in the indirect window,
// two cycles after issue.

`timescale 1ns/1ps

`include "addr_offset_config.svh"

module addr_offset_top (
    input  logic                       clock,
    input  logic                       rst_n,
    input  logic                       access,
    input  addr_offset_pkg::addr_t     raw_addr,
    input  logic                       abort,
    input  addr_offset_pkg::po_write_t ext_write,
    output addr_offset_pkg::thread_t   thread,
    output logic                       result_valid,
    output addr_offset_pkg::addr_t     result_addr,
    output addr_offset_pkg::thread_t   result_thread
);

    // Issue-time state carried to the result stage
    typedef struct packed {
        logic                     access;
        addr_offset_pkg::addr_t   raw_addr;
        logic                     indirect;
        addr_offset_pkg::thread_t thread;
    } issue_t;

    localparam addr_offset_pkg::addr_t window_base = `AO_INDIRECT_BASE;

    addr_offset_pkg::thread_t write_thread;
    addr_offset_pkg::addr_t   programmed_offset;
    logic                     indirect;
    logic                     increment;
    issue_t                   issue_now;
    issue_t                   issue_late;

    thread_sequencer thread_sequencer_i (
        .clock        (clock),
        .rst_n        (rst_n),
        .thread       (thread),
        .write_thread (write_thread)
    );

    // Window is aligned, so the upper bits alone decide
    assign indirect = access &&
        (raw_addr[`AO_ADDR_WIDTH-1:`AO_PO_ADDR_WIDTH] ==
         window_base[`AO_ADDR_WIDTH-1:`AO_PO_ADDR_WIDTH]);

    // Increment request lines up with the write-back cycle
    delay_line #(
        .depth (`AO_THREAD_COUNT - 1),
        .width (1)
    ) increment_dly (
        .clock (clock),
        .rst_n (rst_n),
        .in    (indirect),
        .out   (increment)
    );

    po_memory po_memory_i (
        .clock             (clock),
        .rst_n             (rst_n),
        .read_thread       (thread),
        .write_thread      (write_thread),
        .read_index        (raw_addr[`AO_PO_ADDR_WIDTH-1:0]),
        .increment         (increment),
        .abort             (abort),
        .ext_write         (ext_write),
        .programmed_offset (programmed_offset)
    );

    // Match the two-cycle offset latency
    assign issue_now = '{access: access, raw_addr: raw_addr, indirect: indirect, thread: thread};

    delay_line #(
        .depth (2),
        .width ($bits(issue_t))
    ) issue_dly (
        .clock (clock),
        .rst_n (rst_n),
        .in    (issue_now),
        .out   (issue_late)
    );

    // Sum wraps at the address width
    assign result_valid  = issue_late.access;
    assign result_thread = issue_late.thread;
    assign result_addr   = issue_late.indirect ? issue_late.raw_addr + programmed_offset
                                               : issue_late.raw_addr;

endmodule

// File: hw/delay_line.sv
// Fixed-latency shift register for any payload width.
// A depth of zero gives a plain connection.

`timescale 1ns/1ps

module delay_line #(
    parameter int depth = 1,
    parameter int width = 1
) (
    input  logic             clock,
    input  logic             rst_n,
    input  logic [width-1:0] in,
    output logic [width-1:0] out
);

    if (depth == 0) begin : g_wire
        assign out = in;
    end else begin : g_regs
        // stage[0] is loaded first, stage[depth-1] drives the output
        logic [depth-1:0][width-1:0] stage;

        always_ff @(posedge clock or negedge rst_n) begin
            if (!rst_n) begin
                stage <= '0;
            end else begin
                stage[0] <= in;
                for (int i = 1; i < depth; i++) begin
                    stage[i] <= stage[i-1];
                end
            end
        end

        assign out = stage[depth-1];
    end

endmodule

// File: hw/po_memory.sv
// Per-thread PO/PI memory with self post-increment.
// External writes beat the delayed increment, abort cancels only the increment.

`timescale 1ns/1ps

`include "addr_offset_config.svh"

module po_memory (
    input  logic                       clock,
    input  logic                       rst_n,
    input  addr_offset_pkg::thread_t   read_thread,
    input  addr_offset_pkg::thread_t   write_thread,
    input  addr_offset_pkg::po_index_t read_index,
    input  logic                       increment,
    input  logic                       abort,
    input  addr_offset_pkg::po_write_t ext_write,
    output addr_offset_pkg::addr_t     programmed_offset
);

    localparam int ram_addr_width = `AO_THREAD_WIDTH + `AO_PO_ADDR_WIDTH;

    logic [ram_addr_width-1:0]  ram_read_addr;
    logic [ram_addr_width-1:0]  ram_write_addr;
    addr_offset_pkg::po_entry_t ram_read_data;
    addr_offset_pkg::po_entry_t ram_write_data;
    logic                       ram_wren;
    addr_offset_pkg::po_index_t int_index;
    addr_offset_pkg::po_entry_t int_data;
    logic                       int_grant;
    addr_offset_pkg::po_index_t write_index;
    addr_offset_pkg::addr_t     post_inc;
    addr_offset_pkg::po_entry_t new_entry;

    // ------------------------------------------------------------------
    // Stage 0, read and write arbitration

    assign ram_read_addr = {read_thread, read_index};

    // Index comes back at n+3, one cycle before this thread reads again
    delay_line #(
        .depth (`AO_THREAD_COUNT - 1),
        .width ($bits(addr_offset_pkg::po_index_t))
    ) int_index_dly (
        .clock (clock),
        .rst_n (rst_n),
        .in    (read_index),
        .out   (int_index)
    );

    // Entry is formed one cycle later, so one stage shorter
    delay_line #(
        .depth (`AO_THREAD_COUNT - 2),
        .width ($bits(addr_offset_pkg::po_entry_t))
    ) int_data_dly (
        .clock (clock),
        .rst_n (rst_n),
        .in    (new_entry),
        .out   (int_data)
    );

    // Increment survives only without abort and without an external write
    assign int_grant = increment & ~abort & ~ext_write.wren;
    assign ram_wren  = ext_write.wren | int_grant;

    // Both sources write into write_thread's bank
    assign write_index    = ext_write.wren ? ext_write.index : int_index;
    assign ram_write_data = ext_write.wren ? ext_write.entry : int_data;
    assign ram_write_addr = {write_thread, write_index};

    po_ram po_ram_i (
        .clock      (clock),
        .wren       (ram_wren),
        .write_addr (ram_write_addr),
        .write_data (ram_write_data),
        .read_addr  (ram_read_addr),
        .read_data  (ram_read_data)
    );

    // ------------------------------------------------------------------
    // Stage 1, post-increment and offset output

    // Signed-magnitude increment, wraps at the address width
    always_comb begin
        if (ram_read_data.pi_sign) begin
            post_inc = ram_read_data.offset - addr_offset_pkg::addr_t'(ram_read_data.pi_mag);
        end else begin
            post_inc = ram_read_data.offset + addr_offset_pkg::addr_t'(ram_read_data.pi_mag);
        end
        new_entry        = ram_read_data;
        new_entry.offset = post_inc;
    end

    // Offset before the increment goes to the adder
    always_ff @(posedge clock) begin
        programmed_offset <= ram_read_data.offset;
    end

endmodule

// File: hw/po_ram.sv
// Simple dual-port RAM holding every thread's PO/PI entries.
// One synchronous write port, one registered read port.

`timescale 1ns/1ps

`include "addr_offset_config.svh"

module po_ram (
    input  logic                                          clock,
    input  logic                                          wren,
    input  logic [`AO_THREAD_WIDTH+`AO_PO_ADDR_WIDTH-1:0] write_addr,
    input  addr_offset_pkg::po_entry_t                    write_data,
    input  logic [`AO_THREAD_WIDTH+`AO_PO_ADDR_WIDTH-1:0] read_addr,
    output addr_offset_pkg::po_entry_t                    read_data
);

    // One bank of entries per thread, thread number in the upper address bits
    localparam int word_count = `AO_PO_ENTRY_COUNT * `AO_THREAD_COUNT;

    addr_offset_pkg::po_entry_t mem [word_count];

    // Write port
    always_ff @(posedge clock) begin
        if (wren) begin
            mem[write_addr] <= write_data;
        end
    end

    // Read port, old data on a collision
    // which the thread spacing never produces
    always_ff @(posedge clock) begin
        read_data <= mem[read_addr];
    end

endmodule

// File: hw/thread_sequencer.sv
// Round-robin thread counter for the barrel pipeline.
// Gives the issuing thread and the thread whose write-back is due.

`timescale 1ns/1ps

`include "addr_offset_config.svh"

module thread_sequencer (
    input  logic                     clock,
    input  logic                     rst_n,
    output addr_offset_pkg::thread_t thread,
    output addr_offset_pkg::thread_t write_thread
);

    localparam addr_offset_pkg::thread_t last_thread =
        addr_offset_pkg::thread_t'(`AO_THREAD_COUNT - 1);

    // Issuing thread, one step per cycle
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            thread <= '0;
        end else if (thread == last_thread) begin
            thread <= '0;
        end else begin
            thread <= thread + 1'b1;
        end
    end

    // Write-back thread is the successor of the issuing one
    // i.e. the thread that issued THREAD_COUNT-1 cycles ago
    always_comb begin
        if (thread == last_thread) begin
            write_thread = '0;
        end else begin
            write_thread = thread + 1'b1;
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the address-offset testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    -f flist.f --top-module addr_offset_tb -o addr_offset_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/addr_offset_sim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST OK$" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// File: test/addr_offset_checker.sv
// Reference model and output checks for the address-offset stage.
// Samples the DUT ports at the falling clock edge, mid-cycle, where all are stable.

`timescale 1ns/1ps

`include "addr_offset_config.svh"

module addr_offset_checker (
    input  logic                       clock,
    input  logic                       rst_n,
    input  logic                       access,
    input  addr_offset_pkg::addr_t     raw_addr,
    input  logic                       abort,
    input  addr_offset_pkg::po_write_t ext_write,
    input  addr_offset_pkg::thread_t   thread,
    input  logic                       result_valid,
    input  addr_offset_pkg::addr_t     result_addr,
    input  addr_offset_pkg::thread_t   result_thread,
    output int                         error_count
);

    localparam int thread_count = `AO_THREAD_COUNT;
    localparam int window_base  = `AO_INDIRECT_BASE;
    localparam int addr_span    = 1 << `AO_ADDR_WIDTH;

    // One issued access and the entry it read
    typedef struct packed {
        logic                       access;
        logic                       indirect;
        addr_offset_pkg::addr_t     raw_addr;
        addr_offset_pkg::thread_t   thread;
        addr_offset_pkg::po_index_t index;
        addr_offset_pkg::po_entry_t entry;
    } slot_t;

    addr_offset_pkg::po_entry_t model [thread_count][`AO_PO_ENTRY_COUNT];
    slot_t                      pipe [thread_count-1];
    addr_offset_pkg::thread_t   model_thread;

    initial error_count = 0;

    // Expected address, offset only inside the window, wraps at the address space
    function automatic addr_offset_pkg::addr_t expected_addr(input slot_t s);
        if (!s.indirect) begin
            return s.raw_addr;
        end
        return addr_offset_pkg::addr_t'((int'(s.raw_addr) + int'(s.entry.offset)) % addr_span);
    endfunction

    // Signed-magnitude post-increment
    function automatic addr_offset_pkg::po_entry_t stepped_entry(
        input addr_offset_pkg::po_entry_t e
    );
        int step;
        step = e.pi_sign ? -int'(e.pi_mag) : int'(e.pi_mag);
        e.offset = addr_offset_pkg::addr_t'((int'(e.offset) + step + addr_span) % addr_span);
        return e;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("ERROR at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
        error_count++;
    endtask

    always @(negedge clock) begin : compare
        slot_t                    now;
        slot_t                    due;
        slot_t                    back;
        addr_offset_pkg::thread_t write_thread;
        if (!rst_n) begin
            model_thread = '0;
            for (int i = 0; i < thread_count - 1; i++) begin
                pipe[i] = '0;
            end
            if (result_valid !== 1'b0) report_mismatch("result_valid", 0, result_valid);
            if (thread !== '0) report_mismatch("thread", 0, thread);
        end else begin
            // pipe[1] issued two cycles ago, pipe[2] is due for write-back
            due  = pipe[1];
            back = pipe[thread_count-2];
            if (thread !== model_thread) report_mismatch("thread", model_thread, thread);
            if (result_valid !== due.access) report_mismatch("result_valid", due.access,
                                                             result_valid);
            if (due.access) begin
                if (result_addr !== expected_addr(due)) begin
                    report_mismatch("result_addr", expected_addr(due), result_addr);
                end
                if (result_thread !== due.thread) begin
                    report_mismatch("result_thread", due.thread, result_thread);
                end
            end
            // Read at issue, before this cycle's write to another bank
            now          = '0;
            now.access   = access;
            now.raw_addr = raw_addr;
            now.thread   = model_thread;
            now.indirect = access && int'(raw_addr) >= window_base
                && int'(raw_addr) < window_base + `AO_PO_ENTRY_COUNT;
            if (now.indirect) begin
                now.index = addr_offset_pkg::po_index_t'(int'(raw_addr) - window_base);
                now.entry = model[model_thread][now.index];
            end
            // Write-back slot belongs to the next thread
            write_thread = addr_offset_pkg::thread_t'((int'(model_thread) + 1) % thread_count);
            if (ext_write.wren) begin
                model[write_thread][ext_write.index] = ext_write.entry;
            end else if (back.indirect && !abort) begin
                model[back.thread][back.index] = stepped_entry(back.entry);
            end
            for (int i = thread_count - 2; i > 0; i--) begin
                pipe[i] = pipe[i-1];
            end
            pipe[0]      = now;
            model_thread = addr_offset_pkg::thread_t'((int'(model_thread) + 1) % thread_count);
        end
    end

endmodule

// File: test/addr_offset_sva.sv
// Assertions bound into the address-offset top level.
// Covers reset state, write-enable sanity and the fixed result latency.

`timescale 1ns/1ps

module addr_offset_sva (
    input logic clock,
    input logic rst_n,
    input logic access,
    input logic ram_wren,
    input logic result_valid
);

    // Number of failed assertions so far
    int fail_count = 0;

    // No result while reset is held
    reset_quiet: assert property (@(posedge clock) !rst_n |-> !result_valid)
        else begin
            $error("result_valid high during reset");
            fail_count++;
        end

    // RAM write enable always resolved
    wren_known: assert property (@(posedge clock) disable iff (!rst_n) !$isunknown(ram_wren))
        else begin
            $error("RAM write enable is unknown");
            fail_count++;
        end

    // Results come out exactly two cycles after issue
    valid_latency: assert property (@(posedge clock) disable iff (!rst_n)
        result_valid == $past(access, 2))
        else begin
            $error("result_valid does not follow access by two cycles");
            fail_count++;
        end

endmodule

bind addr_offset_top addr_offset_sva sva_i (
    .clock        (clock),
    .rst_n        (rst_n),
    .access       (access),
    .ram_wren     (po_memory_i.ram_wren),
    .result_valid (result_valid)
);

// File: test/addr_offset_tb.sv
// Testbench for the address-offset stage.
// Loads every PO/PI entry, then runs directed and seeded random accesses.

`timescale 1ns/1ps

`include "addr_offset_config.svh"

module addr_offset_tb;

    // Phase lengths in clock cycles
    localparam int reset_cycles   = 8;
    localparam int idle_cycles    = 8;
    localparam int load_cycles    = `AO_THREAD_COUNT * `AO_PO_ENTRY_COUNT;
    localparam int step_cycles    = 32;
    localparam int abort_cycles   = 24;
    localparam int collide_cycles = 16;
    localparam int pass_cycles    = 16;
    localparam int random_cycles  = 200;
    localparam int drain_cycles   = 4;
    localparam int test_cycles    = reset_cycles + idle_cycles + load_cycles + step_cycles
        + abort_cycles + collide_cycles + pass_cycles + random_cycles + drain_cycles;

    localparam addr_offset_pkg::addr_t window_base = `AO_INDIRECT_BASE;

    logic                       clock;
    logic                       rst_n;
    logic                       access;
    addr_offset_pkg::addr_t     raw_addr;
    logic                       abort;
    addr_offset_pkg::po_write_t ext_write;
    addr_offset_pkg::thread_t   thread;
    logic                       result_valid;
    addr_offset_pkg::addr_t     result_addr;
    addr_offset_pkg::thread_t   result_thread;
    int                         error_count;

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    addr_offset_top dut_i (.*);

    addr_offset_checker checker_i (.*);

    // Drive point, just after the rising edge
    task automatic next_slot();
        @(posedge clock);
        #10;
    endtask

    function automatic addr_offset_pkg::addr_t window_addr(input int unsigned index);
        return window_base + addr_offset_pkg::addr_t'(index % `AO_PO_ENTRY_COUNT);
    endfunction

    // Random external write, or none
    function automatic addr_offset_pkg::po_write_t random_write(input logic enable);
        addr_offset_pkg::po_write_t w;
        w      = addr_offset_pkg::po_write_t'($urandom);
        w.wren = 1'b1;
        return enable ? w : '0;
    endfunction

    initial begin : stimulus
        addr_offset_pkg::thread_t bank;
        void'($urandom(32'h19f2_47ba));
        rst_n     = 1'b1;
        access    = 1'b0;
        raw_addr  = '0;
        abort     = 1'b0;
        ext_write = '0;
        // Falling edge starts the asynchronous reset
        #1 rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clock);
        #10 rst_n = 1'b1;
        repeat (idle_cycles) next_slot();

        // Load every entry through the write thread's bank
        for (int k = 0; k < load_cycles; k++) begin
            next_slot();
            bank            = addr_offset_pkg::thread_t'((int'(thread) + 1) % `AO_THREAD_COUNT);
            ext_write       = random_write(1'b1);
            ext_write.index = addr_offset_pkg::po_index_t'(k / `AO_THREAD_COUNT);
            // Entries 0 and 1 start near the ends so that stepping wraps
            if (k / `AO_THREAD_COUNT == 0) begin
                ext_write.entry = '{offset: 10'h3FC + addr_offset_pkg::addr_t'(bank),
                                    pi_sign: 1'b0, pi_mag: 3'd3};
            end else if (k / `AO_THREAD_COUNT == 1) begin
                ext_write.entry = '{offset: addr_offset_pkg::addr_t'(bank),
                                    pi_sign: 1'b1, pi_mag: 3'd5};
            end
        end

        // Each thread hits one entry twice in a row
        for (int k = 0; k < step_cycles; k++) begin
            next_slot();
            ext_write = '0;
            access    = 1'b1;
            raw_addr  = window_addr(k / (2 * `AO_THREAD_COUNT));
        end

        // Abort every other cycle, half of them with an external write
        for (int k = 0; k < abort_cycles; k++) begin
            next_slot();
            raw_addr  = window_addr($urandom);
            abort     = (k % 2 == 0);
            ext_write = random_write(k % 4 == 0);
        end

        // External writes against pending increments
        for (int k = 0; k < collide_cycles; k++) begin
            next_slot();
            raw_addr  = window_addr($urandom);
            abort     = 1'b0;
            ext_write = random_write(k % 3 == 0);
        end

        // Below the window, with gaps
        for (int k = 0; k < pass_cycles; k++) begin
            next_slot();
            ext_write = '0;
            access    = $urandom_range(0, 1) == 1;
            raw_addr  = addr_offset_pkg::addr_t'($urandom_range(0, int'(window_base) - 1));
        end

        for (int k = 0; k < random_cycles; k++) begin
            next_slot();
            access    = ($urandom % 4) != 0;
            raw_addr  = ($urandom % 2) == 0 ? window_addr($urandom)
                                            : addr_offset_pkg::addr_t'($urandom);
            abort     = ($urandom % 4) == 0;
            ext_write = random_write(($urandom % 8) == 0);
        end

        next_slot();
        access    = 1'b0;
        abort     = 1'b0;
        ext_write = '0;
        repeat (drain_cycles - 1) next_slot();

        $display("Run complete: %0d model mismatches, %0d assertion failures",
                 error_count, dut_i.sva_i.fail_count);
        if (error_count == 0 && dut_i.sva_i.fail_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog sized from the total test length
    initial begin : watchdog
        #((test_cycles + 50) * 100);
        $display("Timeout: the run did not finish within %0d cycles", test_cycles + 50);
        $display("TEST FAILED");
        $finish;
    end

endmodule
